// ==== source/decode_pkg.sv ====
package decode_pkg;

    localparam int DECODE_LANES = 2;
    localparam int LANE_IDX_W   = 1;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;

    typedef logic [31:0] u32;
    typedef logic [63:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [5:0] {
        LB, LH, LW, LD, LBU, LHU, LWU,
        SB, SH, SW, SD,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        JAL, JALR,
        LUI, AUIPC,
        ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
        ADDIW, SLLIW, SRLIW, SRAIW,
        ADD, SUB,
        ILLEGAL
    } decode_op_t;

    // one instruction word, four field layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            reg_idx_t   rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm12;
            reg_idx_t    rs1;
            logic [2:0]  funct3;
            reg_idx_t    rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic [19:0] imm20;
            reg_idx_t    rd;
            logic [6:0]  opcode;
        } u_fmt;
    } instr_t;

    typedef struct packed {
        decode_op_t op;
        reg_idx_t   rd;      // raw field, used or not
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        word_t      sextimm;
        logic       illegal;
    } decoded_t;

endpackage

// ==== source/op_decode.sv ====
module op_decode
    import decode_pkg::*;
(
    input  u32         instruction,
    output decode_op_t op,
    output logic       illegal
);

    instr_t ins;

    assign ins = instruction;

    always_comb begin
        op = ILLEGAL;   // anything unmatched stays illegal
        case (ins.r_fmt.opcode)
            OPC_LOAD: begin
                case (ins.i_fmt.funct3)
                    3'b000:  op = LB;
                    3'b001:  op = LH;
                    3'b010:  op = LW;
                    3'b011:  op = LD;
                    3'b100:  op = LBU;
                    3'b101:  op = LHU;
                    3'b110:  op = LWU;
                    default: op = ILLEGAL;
                endcase
            end
            OPC_STORE: begin
                case (ins.s_fmt.funct3)
                    3'b000:  op = SB;
                    3'b001:  op = SH;
                    3'b010:  op = SW;
                    3'b011:  op = SD;
                    default: op = ILLEGAL;
                endcase
            end
            OPC_BRANCH: begin
                case (ins.s_fmt.funct3)
                    3'b000:  op = BEQ;
                    3'b001:  op = BNE;
                    3'b100:  op = BLT;
                    3'b101:  op = BGE;
                    3'b110:  op = BLTU;
                    3'b111:  op = BGEU;
                    default: op = ILLEGAL;
                endcase
            end
            OPC_JAL:   op = JAL;
            OPC_JALR:  op = (ins.i_fmt.funct3 == 3'b000) ? JALR : ILLEGAL;
            OPC_LUI:   op = LUI;
            OPC_AUIPC: op = AUIPC;
            OPC_OP_IMM: begin
                case (ins.i_fmt.funct3)
                    3'b000: op = ADDI;
                    3'b010: op = SLTI;
                    3'b011: op = SLTIU;
                    3'b100: op = XORI;
                    3'b110: op = ORI;
                    3'b111: op = ANDI;
                    3'b001: op = (ins.r_fmt.funct7[6:1] == 6'b000000) ? SLLI : ILLEGAL;
                    3'b101: begin
                        if (ins.r_fmt.funct7[6:1] == 6'b000000) begin
                            op = SRLI;
                        end else if (ins.r_fmt.funct7[6:1] == 6'b010000) begin
                            op = SRAI;   // bit 30 picks arithmetic
                        end
                    end
                    default: op = ILLEGAL;
                endcase
            end
            OPC_OP_IMM_32: begin
                // W shifts only take a 5-bit shamt, bit 25 must be clear
                case (ins.i_fmt.funct3)
                    3'b000: op = ADDIW;
                    3'b001: op = (ins.r_fmt.funct7 == 7'b0000000) ? SLLIW : ILLEGAL;
                    3'b101: begin
                        if (ins.r_fmt.funct7 == 7'b0000000) begin
                            op = SRLIW;
                        end else if (ins.r_fmt.funct7 == 7'b0100000) begin
                            op = SRAIW;
                        end
                    end
                    default: op = ILLEGAL;
                endcase
            end
            OPC_OP: begin
                if (ins.r_fmt.funct3 == 3'b000) begin
                    if (ins.r_fmt.funct7 == 7'b0000000) begin
                        op = ADD;
                    end else if (ins.r_fmt.funct7 == 7'b0100000) begin
                        op = SUB;
                    end
                end
            end
            default: op = ILLEGAL;
        endcase
    end

    assign illegal = (op == ILLEGAL);

endmodule

// ==== source/extend.sv ====
module extend
    import decode_pkg::*;
(
    input  u32         instruction,
    input  decode_op_t op,
    output word_t      sextimm
);

    always_comb begin
        case (op)
            ADDI, SLTI, SLTIU, XORI, ORI, ANDI,
            ADDIW,
            LB, LH, LW, LD, LBU, LHU, LWU, JALR: begin
                sextimm = {
                    {52{instruction[31]}},
                    instruction[31:20]
                };
            end
            LUI, AUIPC: begin
                sextimm = {
                    {32{instruction[31]}},
                    instruction[31:12],
                    12'b0               // upper immediate sits above bit 12
                };
            end
            SB, SH, SW, SD: begin
                sextimm = {
                    {52{instruction[31]}},
                    instruction[31:25], // imm[11:5]
                    instruction[11:7]   // imm[4:0]
                };
            end
            BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
                sextimm = {
                    {51{instruction[31]}},
                    instruction[31],    // imm[12]
                    instruction[7],     // imm[11]
                    instruction[30:25],
                    instruction[11:8],
                    1'b0
                };
            end
            JAL: begin
                sextimm = {
                    {43{instruction[31]}},
                    instruction[31],    // imm[20]
                    instruction[19:12],
                    instruction[20],    // imm[11]
                    instruction[30:21],
                    1'b0
                };
            end
            SLLI, SRLI, SRAI,
            SLLIW, SRLIW, SRAIW: begin
                sextimm = {
                    58'b0,
                    instruction[25:20]  // shamt, never signed
                };
            end
            default: begin
                sextimm = '0;           // ADD, SUB and illegal words
            end
        endcase
    end

endmodule

// ==== source/decode_lane.sv ====
module decode_lane
    import decode_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     lane_load,
    input  u32       lane_instr,
    input  logic     lane_release,
    output logic     lane_full,
    output decoded_t lane_data
);

    instr_t     ins;
    decode_op_t op;
    logic       illegal;
    word_t      sextimm;

    assign ins = lane_instr;

    op_decode u_op_decode (
        .instruction (lane_instr),
        .op          (op),
        .illegal     (illegal)
    );

    extend u_extend (
        .instruction (lane_instr),
        .op          (op),
        .sextimm     (sextimm)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_full <= 1'b0;
        end else if (lane_load) begin
            lane_full <= 1'b1;
        end else if (lane_release) begin
            lane_full <= 1'b0;   // collector has copied the slot
        end
    end

    always_ff @(posedge clk) begin
        if (lane_load) begin
            lane_data.op      <= op;
            lane_data.rd      <= ins.r_fmt.rd;
            lane_data.rs1     <= ins.r_fmt.rs1;
            lane_data.rs2     <= ins.r_fmt.rs2;
            lane_data.sextimm <= sextimm;
            lane_data.illegal <= illegal;
        end
    end

endmodule

// ==== source/instr_dispatch.sv ====
module instr_dispatch
    import decode_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_req,
    output logic                    in_ack,
    input  u32                      in_instr,
    input  logic [DECODE_LANES-1:0] lane_full,
    output logic [DECODE_LANES-1:0] lane_load,
    output u32                      lane_instr
);

    logic [LANE_IDX_W-1:0] wr_ptr;
    logic                  accept;

    // new word offered, previous handshake done, target slot empty
    assign accept = in_req && !in_ack && !lane_full[wr_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_ack    <= 1'b0;
            lane_load <= '0;
            wr_ptr    <= '0;
        end else begin
            lane_load <= '0;                 // single-cycle pulse
            if (accept) begin
                in_ack            <= 1'b1;
                lane_load[wr_ptr] <= 1'b1;
                if (wr_ptr == LANE_IDX_W'(DECODE_LANES - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end else if (in_ack && !in_req) begin
                in_ack <= 1'b0;              // return to zero
            end
        end
    end

    // held copy, source may move on once it sees ack
    always_ff @(posedge clk) begin
        if (accept) begin
            lane_instr <= in_instr;
        end
    end

endmodule

// ==== source/decode_collect.sv ====
module decode_collect
    import decode_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [DECODE_LANES-1:0] lane_full,
    input  decoded_t                lane_data [DECODE_LANES],
    output logic [DECODE_LANES-1:0] lane_release,
    output logic                    out_req,
    input  logic                    out_ack,
    output decoded_t                out_data
);

    logic [LANE_IDX_W-1:0] rd_ptr;
    logic                  take;

    // only take a new item once the sink has dropped its ack
    assign take = !out_req && !out_ack && lane_full[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_req      <= 1'b0;
            lane_release <= '0;
            rd_ptr       <= '0;
        end else begin
            lane_release <= '0;
            if (take) begin
                out_req              <= 1'b1;
                lane_release[rd_ptr] <= 1'b1;   // slot is free next cycle
                if (rd_ptr == LANE_IDX_W'(DECODE_LANES - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end else if (out_req && out_ack) begin
                out_req <= 1'b0;
            end
        end
    end

    // output register holds while out_req is high
    always_ff @(posedge clk) begin
        if (take) begin
            out_data <= lane_data[rd_ptr];
        end
    end

endmodule

// ==== source/decode_stage.sv ====
module decode_stage
    import decode_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_req,
    output logic     in_ack,
    input  u32       in_instr,
    output logic     out_req,
    input  logic     out_ack,
    output decoded_t out_data
);

    logic [DECODE_LANES-1:0] lane_load;
    logic [DECODE_LANES-1:0] lane_full;
    logic [DECODE_LANES-1:0] lane_release;
    u32                      lane_instr;
    decoded_t                lane_data [DECODE_LANES];

    instr_dispatch u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_req     (in_req),
        .in_ack     (in_ack),
        .in_instr   (in_instr),
        .lane_full  (lane_full),
        .lane_load  (lane_load),
        .lane_instr (lane_instr)
    );

    for (genvar i = 0; i < DECODE_LANES; i++) begin : g_lane
        decode_lane u_lane (
            .clk          (clk),
            .rst_n        (rst_n),
            .lane_load    (lane_load[i]),
            .lane_instr   (lane_instr),    // shared, load picks the lane
            .lane_release (lane_release[i]),
            .lane_full    (lane_full[i]),
            .lane_data    (lane_data[i])
        );
    end

    decode_collect u_collect (
        .clk          (clk),
        .rst_n        (rst_n),
        .lane_full    (lane_full),
        .lane_data    (lane_data),
        .lane_release (lane_release),
        .out_req      (out_req),
        .out_ack      (out_ack),
        .out_data     (out_data)
    );

endmodule

// ==== tb/rv_ref_model.svh ====
function automatic word_t sign_extend(u32 bits, int width);
    logic signed [63:0] t;
    t = {32'b0, bits} << (64 - width);      // move sign bit up to bit 63
    return word_t'(t >>> (64 - width));
endfunction

// weighted choice of format, random fields, some fully random words
function automatic u32 random_instr();
    u32         w;
    logic [2:0] f3;
    w = $random(seed);
    case ($unsigned($random(seed)) % 12)
        0: begin
            w[6:0]   = 7'h03;                // loads
            w[14:12] = 3'($unsigned($random(seed)) % 7);
        end
        1: begin
            w[6:0]   = 7'h23;                // stores
            w[14:12] = 3'($unsigned($random(seed)) % 4);
        end
        2: begin
            f3 = 3'($unsigned($random(seed)) % 6);
            if (f3 > 3'd1) begin
                f3 = f3 + 3'd2;              // skip the two holes
            end
            w[6:0]   = 7'h63;
            w[14:12] = f3;
        end
        3: w[6:0] = 7'h6f;                   // jal
        4: begin
            w[6:0]   = 7'h67;
            w[14:12] = 3'b000;
        end
        5: w[6:0] = 7'h37;                   // lui
        6: w[6:0] = 7'h17;                   // auipc
        7: begin
            w[6:0] = 7'h13;
            if (w[13:12] == 2'b01) begin     // shift-immediates
                w[31]    = 1'b0;
                w[29:26] = 4'b0;
                if (!w[14]) begin
                    w[30] = 1'b0;
                end
            end
        end
        8: begin
            f3       = 3'($unsigned($random(seed)) % 3);
            w[6:0]   = 7'h1b;
            w[14:12] = (f3 == 3'd2) ? 3'b101 : f3;
            if (f3 != 3'd0) begin
                w[31]    = 1'b0;
                w[29:25] = 5'b0;             // 5-bit shamt only
                if (f3 == 3'd1) begin
                    w[30] = 1'b0;
                end
            end
        end
        9: begin
            w[6:0]   = 7'h33;                // add or sub by bit 30
            w[14:12] = 3'b000;
            w[31]    = 1'b0;
            w[29:25] = 5'b0;
        end
        default: begin
        end
    endcase
    return w;
endfunction

function automatic decoded_t expected_decode(u32 w);
    decoded_t   d;
    logic [2:0] f3;
    logic [6:0] f7;
    byte        fmt;
    f3   = w[14:12];
    f7   = w[31:25];
    d.op = ILLEGAL;
    fmt  = "N";
    case (w[6:0])
        7'h03: begin
            fmt = "I";
            if (f3 != 3'b111) begin
                d.op = decode_op_t'(6'(LB) + 6'(f3));
            end
        end
        7'h23: begin
            fmt = "S";
            if (!f3[2]) begin
                d.op = decode_op_t'(6'(SB) + 6'(f3));
            end
        end
        7'h63: begin
            fmt = "B";
            if (f3[2]) begin
                d.op = decode_op_t'(6'(BLT) + 6'(f3[1:0]));
            end else if (!f3[1]) begin
                d.op = f3[0] ? BNE : BEQ;
            end
        end
        7'h6f: begin
            fmt  = "J";
            d.op = JAL;
        end
        7'h67: begin
            fmt = "I";
            if (f3 == 3'b000) begin
                d.op = JALR;
            end
        end
        7'h37: begin
            fmt  = "U";
            d.op = LUI;
        end
        7'h17: begin
            fmt  = "U";
            d.op = AUIPC;
        end
        7'h13: begin
            fmt = "I";
            case (f3)
                3'd0: d.op = ADDI;
                3'd2: d.op = SLTI;
                3'd3: d.op = SLTIU;
                3'd4: d.op = XORI;
                3'd6: d.op = ORI;
                3'd7: d.op = ANDI;
                default: begin
                    fmt = "H";
                    if (w[31:26] == 6'b000000) begin
                        d.op = (f3 == 3'd1) ? SLLI : SRLI;
                    end else if (f3 == 3'd5 && w[31:26] == 6'b010000) begin
                        d.op = SRAI;
                    end
                end
            endcase
        end
        7'h1b: begin
            fmt = (f3 == 3'd0) ? "I" : "H";
            if (f3 == 3'd0) begin
                d.op = ADDIW;
            end else if (f3 == 3'd1 && f7 == 7'h00) begin
                d.op = SLLIW;
            end else if (f3 == 3'd5 && f7 == 7'h00) begin
                d.op = SRLIW;
            end else if (f3 == 3'd5 && f7 == 7'h20) begin
                d.op = SRAIW;
            end
        end
        7'h33: begin
            if (f3 == 3'd0 && f7 == 7'h00) begin
                d.op = ADD;
            end else if (f3 == 3'd0 && f7 == 7'h20) begin
                d.op = SUB;
            end
        end
        default: begin
        end
    endcase
    d.illegal = (d.op == ILLEGAL);
    d.rd      = w[11:7];
    d.rs1     = w[19:15];
    d.rs2     = w[24:20];
    if (d.illegal) begin
        fmt = "N";
    end
    case (fmt)
        "I": d.sextimm = sign_extend({20'b0, w[31:20]}, 12);
        "U": d.sextimm = sign_extend({w[31:12], 12'b0}, 32);
        "S": d.sextimm = sign_extend({20'b0, w[31:25], w[11:7]}, 12);
        "B": d.sextimm = sign_extend({19'b0, w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
        "J": d.sextimm = sign_extend({11'b0, w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
        "H": d.sextimm = {58'b0, w[25:20]};
        default: d.sextimm = '0;
    endcase
    return d;
endfunction

// ==== tb/decode_tb.sv ====
module decode_tb
    import decode_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_INSTR = 400;
    localparam int TIMEOUT   = 1000;   // cycles per wait

    logic     clk = 1'b0;
    logic     rst_n;
    logic     in_req;
    logic     in_ack;
    u32       in_instr;
    logic     out_req;
    logic     out_ack;
    decoded_t out_data;

    integer   seed = 49242;
    decoded_t exp_q [$];               // scoreboard, oldest first
    int       n_sent;
    int       n_recv;
    int       n_out;                   // out_req rises seen by the monitor
    logic     prev_in_ack;
    logic     prev_out_req;
    decoded_t prev_out_data;

    `include "rv_ref_model.svh"

    decode_stage UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .in_instr (in_instr),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .out_data (out_data)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [127:0] actual, logic [127:0] expected);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s actual=%0h expected=%0h", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic wait_in_ack(logic level);
        int cycles;
        cycles = 0;
        while (in_ack !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("timed out waiting for in_ack to become %0b", level);
                stop_with_failure();
            end
        end
    endtask

    task automatic wait_out_req(logic level);
        int cycles;
        cycles = 0;
        while (out_req !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("timed out waiting for out_req to become %0b", level);
                stop_with_failure();
            end
        end
    endtask

    task automatic send_all();
        u32 w;
        int gap;
        for (int i = 0; i < NUM_INSTR; i++) begin
            gap = int'($unsigned($random(seed)) % 6);
            repeat (gap) @(negedge clk);
            w = random_instr();
            exp_q.push_back(expected_decode(w));
            in_instr = w;
            in_req   = 1'b1;
            n_sent++;
            wait_in_ack(1'b1);
            in_req   = 1'b0;
            in_instr = $random(seed);   // dispatcher must hold its own copy
            wait_in_ack(1'b0);
        end
    endtask

    task automatic receive_all();
        decoded_t want;
        int       stall;
        while (n_recv < NUM_INSTR) begin
            wait_out_req(1'b1);
            stall = ($unsigned($random(seed)) % 8 == 0) ? int'($unsigned($random(seed)) % 41)
                                                        : int'($unsigned($random(seed)) % 4);
            repeat (stall) @(negedge clk);
            if (exp_q.size() == 0) begin
                $display("an output item arrived with no instruction outstanding");
                stop_with_failure();
            end
            want = exp_q.pop_front();
            check_value("out_data.op", 128'(out_data.op), 128'(want.op));
            check_value("out_data.rd", 128'(out_data.rd), 128'(want.rd));
            check_value("out_data.rs1", 128'(out_data.rs1), 128'(want.rs1));
            check_value("out_data.rs2", 128'(out_data.rs2), 128'(want.rs2));
            check_value("out_data.sextimm", 128'(out_data.sextimm), 128'(want.sextimm));
            check_value("out_data.illegal", 128'(out_data.illegal), 128'(want.illegal));
            out_ack = 1'b1;
            n_recv++;
            wait_out_req(1'b0);
            out_ack = 1'b0;
        end
    endtask

    // handshake order, sampled just after each rising edge
    always @(posedge clk) begin
        #1;
        if (rst_n) begin
            if (in_ack && !prev_in_ack) begin
                check_value("in_req at in_ack rise", 128'(in_req), 128'(1'b1));
            end
            if (out_req && !prev_out_req) begin
                check_value("out_ack at out_req rise", 128'(out_ack), 128'(1'b0));
                n_out++;
            end
            if (out_req && prev_out_req) begin
                check_value("out_data while out_req high", 128'(out_data), 128'(prev_out_data));
            end
        end
        prev_in_ack   = in_ack;
        prev_out_req  = out_req;
        prev_out_data = out_data;
    end

    initial begin
        rst_n         = 1'b0;
        in_req        = 1'b0;
        in_instr      = '0;
        out_ack       = 1'b0;
        n_sent        = 0;
        n_recv        = 0;
        n_out         = 0;
        prev_in_ack   = 1'b0;
        prev_out_req  = 1'b0;
        prev_out_data = '0;
        repeat (8) begin
            @(negedge clk);
            check_value("in_ack in reset", 128'(in_ack), 128'(1'b0));
            check_value("out_req in reset", 128'(out_req), 128'(1'b0));
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_value("in_ack after reset", 128'(in_ack), 128'(1'b0));
        check_value("out_req after reset", 128'(out_req), 128'(1'b0));
        fork
            send_all();
            receive_all();
        join
        repeat (20) @(negedge clk);    // a stray extra item would be offered by now
        if (exp_q.size() == 0 && n_out == n_sent) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("%0d sent, %0d offered, %0d left in the scoreboard",
                     n_sent, n_out, exp_q.size());
            stop_with_failure();
        end
    end

endmodule

// ==== src.f ====
+incdir+tb
source/decode_pkg.sv
source/op_decode.sv
source/extend.sv
source/decode_lane.sv
source/instr_dispatch.sv
source/decode_collect.sv
source/decode_stage.sv
tb/decode_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the decode stage testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module decode_tb -f src.f -Mdir obj_dir -o decode_sim \
    > sim.log 2>&1 \
    && ./obj_dir/decode_sim >> sim.log 2>&1 \
    || echo "TESTBENCH FAILED" >> sim.log
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0
